/* all.f */
+incdir+include
hw/cachePkg.sv
hw/cacheLookup.sv
hw/cacheController.sv
hw/cacheData.sv
hw/blockMemory.sv
hw/dataCacheTop.sv
verif/dataCacheTb.sv

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator, from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module dataCacheTb -f all.f

out=$(./obj_dir/VdataCacheTb)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

/* verif/memImage.hex */
// one 32-bit word per line, word i holds a5000000 plus i
A5000000
A5000001
A5000002
A5000003
A5000004
A5000005
A5000006
A5000007
A5000008
A5000009
A500000A
A500000B
A500000C
A500000D
A500000E
A500000F
A5000010
A5000011
A5000012
A5000013
A5000014
A5000015
A5000016
A5000017
A5000018
A5000019
A500001A
A500001B
A500001C
A500001D
A500001E
A500001F
A5000020
A5000021
A5000022
A5000023
A5000024
A5000025
A5000026
A5000027
A5000028
A5000029
A500002A
A500002B
A500002C
A500002D
A500002E
A500002F
A5000030
A5000031
A5000032
A5000033
A5000034
A5000035
A5000036
A5000037
A5000038
A5000039
A500003A
A500003B
A500003C
A500003D
A500003E
A500003F

/* include/tbVectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// stimulus table, one access per line
// columns are name, op, byte address, store data, expected load data, latency class
// image words come from imageWord(), stored words are repeated as literals
task automatic buildVectorTable();
  // line 4, tag 0 brought in, then hit and made dirty
  addVector("loadMissClean", OP_LOAD, 32'h040, 32'h0, imageWord(32'h040), latClean);
  addVector("loadHitSameBlock", OP_LOAD, 32'h048, 32'h0, imageWord(32'h048), latHit);
  addVector("storeHit", OP_STORE, 32'h044, 32'h1122_3344, 32'h0, latHit);
  addVector("loadAfterStore", OP_LOAD, 32'h044, 32'h0, 32'h1122_3344, latHit);
  addVector("loadOtherWord", OP_LOAD, 32'h04C, 32'h0, imageWord(32'h04C), latHit);
  // tag 1 on line 4 pushes the dirty block out
  addVector("loadDirtyEvict", OP_LOAD, 32'h0C0, 32'h0, imageWord(32'h0C0), latDirty);
  addVector("storeHitNewTag", OP_STORE, 32'h0CC, 32'hCAFE_F00D, 32'h0, latHit);
  // stored word must come back from memory
  addVector("reloadEvicted", OP_LOAD, 32'h044, 32'h0, 32'h1122_3344, latDirty);
  addVector("loadEvictedNeighbor", OP_LOAD, 32'h040, 32'h0, imageWord(32'h040), latHit);
  addVector("reloadSecondVictim", OP_LOAD, 32'h0CC, 32'h0, 32'hCAFE_F00D, latClean);
  // line 2 allocated by a store miss
  addVector("storeMissAlloc", OP_STORE, 32'h028, 32'h5A5A_1234, 32'h0, latClean);
  addVector("loadStoreMissWord", OP_LOAD, 32'h028, 32'h0, 32'h5A5A_1234, latHit);
  addVector("loadAllocWord0", OP_LOAD, 32'h020, 32'h0, imageWord(32'h020), latHit);
  addVector("loadAllocWord1", OP_LOAD, 32'h024, 32'h0, imageWord(32'h024), latHit);
  addVector("loadAllocWord3", OP_LOAD, 32'h02C, 32'h0, imageWord(32'h02C), latHit);
  // store miss over a dirty line, then both blocks read back
  addVector("storeMissDirty", OP_STORE, 32'h0A8, 32'h0BAD_C0DE, 32'h0, latDirty);
  addVector("reloadStoreMissBlock", OP_LOAD, 32'h028, 32'h0, 32'h5A5A_1234, latDirty);
  addVector("reloadDirtyStore", OP_LOAD, 32'h0A8, 32'h0, 32'h0BAD_C0DE, latClean);
  addVector("loadRefillNeighbor", OP_LOAD, 32'h0A4, 32'h0, imageWord(32'h0A4), latHit);
endtask

`endif

/* verif/dataCacheTb.sv */
`timescale 1ns/100ps

module dataCacheTb
  import cachePkg::*;
();

  // latency classes in cycles from req sampled to ready
  localparam int latHit = 1;
  localparam int latClean = 6;
  localparam int latDirty = 10;
  localparam int idleCycles = 5;

  logic        clk;
  logic        rstN;
  logic        req;
  cacheOp_t    op;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        ready;

  // vector table columns
  string       vecName[$];
  cacheOp_t    vecOp[$];
  logic [31:0] vecAddr[$];
  logic [31:0] vecWdata[$];
  logic [31:0] vecExpData[$];
  int          vecLatency[$];

  int errorCount;
  int testsRun;
  int testsFailed;
  int cycleCount;
  int cycleLimit;

  dataCacheTop u_dataCacheTop (
    .clk(clk), .rstN(rstN), .req(req), .op(op), .addr(addr), .wdata(wdata),
    .rdata(rdata), .ready(ready)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // run limit, hit only when the cache stops answering
  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("timeout: no response from the cache after %0d cycles", cycleCount);
      $display("Test failed");
      $finish;
    end
  end

  // image rule, word i holds a5000000 plus i
  function automatic logic [31:0] imageWord(logic [31:0] byteAddr);
    return 32'hA500_0000 + {22'b0, byteAddr[11:2]};
  endfunction

  task automatic addVector(string name, cacheOp_t opVal, logic [31:0] addrVal,
                           logic [31:0] dataVal, logic [31:0] expData, int latency);
    vecName.push_back(name);
    vecOp.push_back(opVal);
    vecAddr.push_back(addrVal);
    vecWdata.push_back(dataVal);
    vecExpData.push_back(expData);
    vecLatency.push_back(latency);
  endtask

  `include "tbVectors.svh"

  task automatic compareValue(string testName, string what, logic [31:0] expected,
                              logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("FAILED %s %s: expected %h, actual %h", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  // one status line per finished test
  task automatic finishTest(string testName, int errorsBefore);
    testsRun++;
    if (errorCount == errorsBefore)
    begin
      $display("done %s: ok", testName);
    end
    else
    begin
      testsFailed++;
      $display("done %s: mismatches seen", testName);
    end
  endtask

  // no request, so ready must stay low
  task automatic checkIdle();
    int errorsBefore;
    errorsBefore = errorCount;
    repeat (idleCycles)
    begin
      @(negedge clk);
      compareValue("resetIdle", "ready", 32'h0, {31'b0, ready});
    end
    @(posedge clk);
    #1;
    finishTest("resetIdle", errorsBefore);
  endtask

  // called 1 ns after an edge; holds the request until ready
  task automatic runVector(int i);
    int cycles;
    int errorsBefore;
    errorsBefore = errorCount;
    req = 1'b1;
    op = vecOp[i];
    addr = vecAddr[i];
    wdata = vecWdata[i];
    // edge where req is first sampled
    @(posedge clk);
    cycles = 0;
    // ready and rdata sampled mid cycle
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (ready !== 1'b1);
    compareValue(vecName[i], "latency", vecLatency[i], cycles);
    if (vecOp[i] == OP_LOAD)
    begin
      compareValue(vecName[i], "rdata", vecExpData[i], rdata);
    end
    // ready seen on this edge, request dropped after it
    @(posedge clk);
    #1;
    req = 1'b0;
    finishTest(vecName[i], errorsBefore);
  endtask

  initial
  begin
    clk = 1'b0;
    rstN = 1'b0;
    req = 1'b0;
    op = OP_LOAD;
    addr = '0;
    wdata = '0;
    errorCount = 0;
    testsRun = 0;
    testsFailed = 0;
    cycleCount = 0;
    buildVectorTable();
    cycleLimit = vecName.size() * 10 + 50;
    // reset held over two edges
    repeat (2) @(posedge clk);
    #1;
    rstN = 1'b1;
    checkIdle();
    for (int i = 0; i < vecName.size(); i++)
    begin
      runVector(i);
    end
    repeat (2) @(posedge clk);
    $display("summary: %0d tests, %0d failed, %0d mismatches", testsRun, testsFailed,
             errorCount);
    if (errorCount == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* hw/dataCacheTop.sv */
`timescale 1ns/100ps

module dataCacheTop
  import cachePkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 req,
  input  cacheOp_t             op,
  input  logic [ADDR_BITS-1:0] addr,
  input  logic [WORD_BITS-1:0] wdata,
  output logic [WORD_BITS-1:0] rdata,
  output logic                 ready
);

  // lookup results
  logic                   hit;
  logic                   dirty;
  logic [TAG_BITS-1:0]    victimTag;
  logic [INDEX_BITS-1:0]  index;
  logic [OFFSET_BITS-1:0] offset;

  // controller strobes
  logic tagWrite;
  logic markDirty;
  logic refillWrite;
  logic storeWrite;
  logic loadCapture;

  // memory port
  logic                  memRe;
  logic                  memWe;
  logic                  memValid;
  logic [ADDR_BITS-1:0]  memAddr;
  logic [BLOCK_BITS-1:0] memRdata;
  logic [BLOCK_BITS-1:0] victimBlock;

  cacheLookup u_cacheLookup (
    .clk(clk), .rstN(rstN), .addr(addr), .tagWrite(tagWrite), .markDirty(markDirty),
    .hit(hit), .dirty(dirty), .victimTag(victimTag), .index(index), .offset(offset)
  );

  cacheController u_cacheController (
    .clk(clk), .rstN(rstN), .req(req), .op(op), .addr(addr), .hit(hit), .dirty(dirty),
    .victimTag(victimTag), .index(index), .memValid(memValid), .tagWrite(tagWrite),
    .markDirty(markDirty), .refillWrite(refillWrite), .storeWrite(storeWrite),
    .loadCapture(loadCapture), .memRe(memRe), .memWe(memWe), .ready(ready),
    .memAddr(memAddr)
  );

  cacheData u_cacheData (
    .clk(clk), .index(index), .offset(offset), .wdata(wdata), .memRdata(memRdata),
    .refillWrite(refillWrite), .storeWrite(storeWrite), .loadCapture(loadCapture),
    .victimBlock(victimBlock), .rdata(rdata)
  );

  // main memory behind the cache
  blockMemory u_blockMemory (
    .clk(clk), .rstN(rstN), .memRe(memRe), .memWe(memWe), .memAddr(memAddr),
    .victimBlock(victimBlock), .memRdata(memRdata), .memValid(memValid)
  );

endmodule

/* hw/blockMemory.sv */
`timescale 1ns/100ps

module blockMemory
  import cachePkg::*;
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  memRe,
  input  logic                  memWe,
  input  logic [ADDR_BITS-1:0]  memAddr,
  input  logic [BLOCK_BITS-1:0] victimBlock,
  output logic [BLOCK_BITS-1:0] memRdata,
  output logic                  memValid
);

  memState_t state, nextState;
  logic [WAIT_BITS-1:0] waitCount;

  // word array and block select, offset bits dropped
  logic [WORD_BITS-1:0] mem [MEM_WORDS];
  logic [BLOCK_ADDR_BITS-1:0] blockAddr;
  logic accept;

  assign blockAddr = memAddr[INDEX_LSB +: BLOCK_ADDR_BITS];

  // a new request is taken whenever the memory is not busy
  assign accept = (state != MEM_BUSY) && (memRe || memWe);

  always_ff @(posedge clk)
  begin
    if (!rstN)
      state <= MEM_IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      MEM_IDLE:
        if (accept)
          nextState = MEM_BUSY;
      MEM_BUSY:
        if (waitCount == WAIT_BITS'(WAIT_CYCLES))
          nextState = MEM_DONE;
      MEM_DONE:
        nextState = accept ? MEM_BUSY : MEM_IDLE;
      default:
        nextState = MEM_IDLE;
    endcase
  end

  // busy lasts WAIT_CYCLES plus one cycles
  always_ff @(posedge clk)
  begin
    if (!rstN || (state != MEM_BUSY))
      waitCount <= '0;
    else
      waitCount <= waitCount + 1'b1;
  end

  initial
  begin
    $readmemh(MEM_IMAGE, mem);
  end

  // write on the first edge of the request
  // read data refreshed while busy, steady in the done cycle
  always_ff @(posedge clk)
  begin
    for (int w = 0; w < BLOCK_WORDS; w++)
    begin
      if (accept && memWe)
        mem[{blockAddr, OFFSET_BITS'(w)}] <= victimBlock[w*WORD_BITS +: WORD_BITS];
      if (state == MEM_BUSY)
        memRdata[w*WORD_BITS +: WORD_BITS] <= mem[{blockAddr, OFFSET_BITS'(w)}];
    end
  end

  assign memValid = (state == MEM_DONE);

  // requester must hold the address through the wait
  assert property (@(posedge clk) disable iff (!rstN) (state == MEM_BUSY) |-> $stable(memAddr))
    else $error("memory address changed during a request");

endmodule

/* hw/cacheData.sv */
`timescale 1ns/100ps

module cacheData
  import cachePkg::*;
(
  input  logic                   clk,
  input  logic [INDEX_BITS-1:0]  index,
  input  logic [OFFSET_BITS-1:0] offset,
  input  logic [WORD_BITS-1:0]   wdata,
  input  logic [BLOCK_BITS-1:0]  memRdata,
  input  logic                   refillWrite,
  input  logic                   storeWrite,
  input  logic                   loadCapture,
  output logic [BLOCK_BITS-1:0]  victimBlock,
  output logic [WORD_BITS-1:0]   rdata
);

  // block array, word 0 in the low bits as in memory
  logic [BLOCK_WORDS-1:0][WORD_BITS-1:0] blocks [LINES];

  // word of the indexed line selected by the offset
  logic [WORD_BITS-1:0] selWord;

  assign selWord = blocks[index][offset];

  // refill replaces the whole block
  // a store only touches its own word
  always_ff @(posedge clk)
  begin
    if (refillWrite)
    begin
      blocks[index] <= memRdata;
    end
    else if (storeWrite)
    begin
      blocks[index][offset] <= wdata;
    end
  end

  // load result
  // held until the next load so it stays valid after ready
  always_ff @(posedge clk)
  begin
    if (loadCapture)
    begin
      rdata <= selWord;
    end
  end

  // whole indexed block goes out on write-back
  assign victimBlock = blocks[index];

endmodule

/* hw/cacheController.sv */
`timescale 1ns/100ps

module cacheController
  import cachePkg::*;
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  req,
  input  cacheOp_t              op,
  input  logic [ADDR_BITS-1:0]  addr,
  input  logic                  hit,
  input  logic                  dirty,
  input  logic [TAG_BITS-1:0]   victimTag,
  input  logic [INDEX_BITS-1:0] index,
  input  logic                  memValid,
  output logic                  tagWrite,
  output logic                  markDirty,
  output logic                  refillWrite,
  output logic                  storeWrite,
  output logic                  loadCapture,
  output logic                  memRe,
  output logic                  memWe,
  output logic                  ready,
  output logic [ADDR_BITS-1:0]  memAddr
);

  ctrlState_t state, nextState;

  // request decode in idle
  logic idleReq;
  logic idleMiss;
  // cycle in which the request is served out of the cache
  logic hitServe;
  logic [ADDR_BITS-1:0] victimAddr;
  logic [ADDR_BITS-1:0] fillAddr;

  assign idleReq  = (state == IDLE) && req;
  assign idleMiss = idleReq && !hit;

  // update replays the access on the freshly installed line
  assign hitServe = (idleReq && hit) || (state == UPDATE);

  always_ff @(posedge clk)
  begin
    if (!rstN)
      state <= IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      IDLE:
        if (req)
          nextState = hit ? RESPOND : (dirty ? WRITEBACK : REFILL);
      WRITEBACK:
        if (memValid)
          nextState = REFILL;
      REFILL:
        if (memValid)
          nextState = UPDATE;
      UPDATE:
        nextState = RESPOND;
      RESPOND:
        nextState = IDLE;
      default:
        nextState = IDLE;
    endcase
  end

  // store merge and dirty mark share one edge on a hit
  assign storeWrite  = hitServe && (op == OP_STORE);
  assign markDirty   = hitServe && (op == OP_STORE);
  assign loadCapture = hitServe && (op == OP_LOAD);

  // install block and tag on the edge into update
  assign refillWrite = (state == REFILL) && memValid;
  assign tagWrite    = (state == REFILL) && memValid;

  // memory requests start in idle so the wait overlaps the first state cycle
  // write-back hands over to the refill read in its valid cycle
  assign memWe = (idleMiss && dirty) || ((state == WRITEBACK) && !memValid);
  assign memRe = (idleMiss && !dirty) || ((state == WRITEBACK) && memValid)
               || ((state == REFILL) && !memValid);

  // victim address from the stored tag and fill address from the cpu
  assign victimAddr = {{(ADDR_BITS - TAG_LSB - TAG_BITS){1'b0}}, victimTag, index,
                       {INDEX_LSB{1'b0}}};
  assign fillAddr   = {addr[ADDR_BITS-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
  assign memAddr    = memWe ? victimAddr : fillAddr;

  assign ready = (state == RESPOND);

  assert property (@(posedge clk) disable iff (!rstN) !(memRe && memWe))
    else $error("memory read and write requested together");

  // the installed tag must make the replayed access hit
  assert property (@(posedge clk) disable iff (!rstN) (state == UPDATE) |-> hit)
    else $error("replay after refill missed");

endmodule

/* hw/cacheLookup.sv */
`timescale 1ns/100ps

module cacheLookup
  import cachePkg::*;
(
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [ADDR_BITS-1:0]   addr,
  input  logic                   tagWrite,
  input  logic                   markDirty,
  output logic                   hit,
  output logic                   dirty,
  output logic [TAG_BITS-1:0]    victimTag,
  output logic [INDEX_BITS-1:0]  index,
  output logic [OFFSET_BITS-1:0] offset
);

  // requested tag from the cpu address
  logic [TAG_BITS-1:0] reqTag;

  // per line state
  logic [TAG_BITS-1:0] tags [LINES];
  logic [LINES-1:0]    validBits;
  logic [LINES-1:0]    dirtyBits;

  // address split
  // bits 11:7 tag, 6:4 line, 3:2 word
  assign reqTag = addr[TAG_LSB +: TAG_BITS];
  assign index  = addr[INDEX_LSB +: INDEX_BITS];
  assign offset = addr[OFFSET_LSB +: OFFSET_BITS];

  // tag store, written only when a refilled block is installed
  always_ff @(posedge clk)
  begin
    if (tagWrite)
    begin
      tags[index] <= reqTag;
    end
  end

  // valid and dirty bits
  // install sets valid and leaves the line clean
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      validBits <= '0;
      dirtyBits <= '0;
    end
    else if (tagWrite)
    begin
      validBits[index] <= 1'b1;
      dirtyBits[index] <= 1'b0;
    end
    else if (markDirty)
    begin
      dirtyBits[index] <= 1'b1;
    end
  end

  // hit check on the indexed line
  assign hit = validBits[index] && (tags[index] == reqTag);

  // current occupant, used for the write-back decision and address
  assign dirty     = validBits[index] && dirtyBits[index];
  assign victimTag = tags[index];

  // install comes from a refill, dirty from a store hit; never in one cycle
  assert property (@(posedge clk) disable iff (!rstN) !(tagWrite && markDirty))
    else $error("tag install and dirty mark in the same cycle");

endmodule

/* hw/cachePkg.sv */
package cachePkg;

  // cpu side address and data
  localparam int ADDR_BITS = 32;
  localparam int WORD_BITS = 32;

  // cache geometry
  localparam int BLOCK_WORDS = 4;
  localparam int BLOCK_BITS = WORD_BITS * BLOCK_WORDS;
  localparam int LINES = 8;
  localparam int OFFSET_BITS = $clog2(BLOCK_WORDS);
  localparam int INDEX_BITS = $clog2(LINES);
  localparam int TAG_BITS = 5;

  // field positions, byte offset is bits 1:0
  localparam int OFFSET_LSB = 2;
  localparam int INDEX_LSB = OFFSET_LSB + OFFSET_BITS;
  localparam int TAG_LSB = INDEX_LSB + INDEX_BITS;

  // main memory model
  localparam int MEM_WORDS = 1024;
  localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
  localparam int BLOCK_ADDR_BITS = MEM_ADDR_BITS - OFFSET_BITS;
  localparam int WAIT_CYCLES = 2;
  localparam int WAIT_BITS = $clog2(WAIT_CYCLES + 1);
  localparam string MEM_IMAGE = "verif/memImage.hex";

  typedef enum logic {OP_LOAD, OP_STORE} cacheOp_t;

  typedef enum logic [2:0] {IDLE, WRITEBACK, REFILL, UPDATE, RESPOND} ctrlState_t;

  typedef enum logic [1:0] {MEM_IDLE, MEM_BUSY, MEM_DONE} memState_t;

endpackage
